/* flist.f */
rtl/colmix_pkg.sv
rtl/video_timer.sv
rtl/colmix_axil_fsm.sv
rtl/layer_priority.sv
rtl/palette_ram.sv
rtl/blank_delay.sv
rtl/colmix_top.sv
verif/colmix_tb.sv

/* rtl/blank_delay.sv */
// Blanking alignment: delays the blank flags by the pipeline depth and blacks out blanked colour
`timescale 1ns/1ps

module blank_delay (
    input  logic               clk,
    input  logic               reset,
    input  colmix_pkg::vid_t   vid,
    input  colmix_pkg::color_t color_in,
    output colmix_pkg::color_t color,
    output logic               hblank_n_dly,
    output logic               vblank_n_dly
);

    logic [2:0]         hb_sr;
    logic [2:0]         vb_sr;
    colmix_pkg::color_t color_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            hb_sr <= '0;
            vb_sr <= '0;
        end else if (vid.pxl_cen) begin
            hb_sr <= {hb_sr[1:0], vid.hblank_n};
            vb_sr <= {vb_sr[1:0], vid.vblank_n};
        end
    end

    // Palette output captured with the last flag stage
    always_ff @(posedge clk) begin
        if (vid.pxl_cen) begin
            color_q <= color_in;
        end
    end

    assign hblank_n_dly = hb_sr[2];
    assign vblank_n_dly = vb_sr[2];
    assign color        = (hblank_n_dly && vblank_n_dly) ? color_q : '0;

endmodule

/* rtl/colmix_axil_fsm.sv */
// AXI4-Lite slave giving the CPU access to the palette, the priority table and the control register
`timescale 1ns/1ps

module colmix_axil_fsm (
    input  logic                  clk,
    input  logic                  reset,
    input  colmix_pkg::axi_addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  colmix_pkg::axi_data_t wdata,
    input  colmix_pkg::axi_strb_t wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  colmix_pkg::axi_addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output colmix_pkg::axi_data_t rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output colmix_pkg::pal_wr_t   pal_wr,
    output colmix_pkg::pal_addr_t pal_rd_addr,
    input  colmix_pkg::color_t    pal_rd_data,
    output colmix_pkg::prio_wr_t  prio_wr,
    output colmix_pkg::ctrl_t     ctrl
);

    localparam logic [1:0] REG_PAL  = 2'd0;
    localparam logic [1:0] REG_PRIO = 2'd1;
    localparam logic [1:0] REG_CTRL = 2'd2;
    localparam logic [1:0] REG_NONE = 2'd3;

    colmix_pkg::axil_state_e state;
    colmix_pkg::axi_addr_t   rd_addr_q;
    logic [1:0]              wr_reg;
    logic [1:0]              rd_reg;
    logic                    wr_fire;
    logic                    rd_fire;
    logic                    wr_ok;

    // Region decode, bits 1:0 are the byte offset and ignored
    function automatic logic [1:0] decode(input colmix_pkg::axi_addr_t a);
        if (a[15:12] == colmix_pkg::PAL_BASE[15:12]) begin
            return REG_PAL;
        end else if (a[15:12] == colmix_pkg::PRIO_BASE[15:12]) begin
            return REG_PRIO;
        end else if (a[15:2] == colmix_pkg::CTRL_ADDR[15:2]) begin
            return REG_CTRL;
        end
        return REG_NONE;
    endfunction

    // Write needs both AW and W, and beats a waiting read
    assign wr_fire = (state == colmix_pkg::IDLE) && awvalid && wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = (state == colmix_pkg::IDLE) && arvalid && !awvalid && !wvalid;
    assign rd_fire = arready && arvalid;

    assign wr_reg = decode(awaddr);
    assign wr_ok  = (wr_reg == REG_PAL) || (wr_reg == REG_PRIO) ||
                    (wr_reg == REG_CTRL && wstrb[0]);

    // RAM strobes sit on the transfer cycle
    always_comb begin
        pal_wr.we    = wr_fire && (wr_reg == REG_PAL);
        pal_wr.addr  = awaddr[11:2];
        pal_wr.data  = '{red: wdata[23:16], green: wdata[15:8], blue: wdata[7:0]};
        pal_wr.be    = wstrb[2:0];
        prio_wr.we   = wr_fire && (wr_reg == REG_PRIO) && wstrb[0];
        prio_wr.addr = awaddr[11:2];
        prio_wr.sel  = colmix_pkg::layer_sel_e'(wdata[1:0]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= colmix_pkg::IDLE;
            ctrl  <= colmix_pkg::CTRL_RESET;
        end else begin
            case (state)
                colmix_pkg::IDLE: begin
                    if (wr_fire) begin
                        state <= colmix_pkg::WR_RESP;
                        if (wr_reg == REG_CTRL && wstrb[0]) begin
                            ctrl <= colmix_pkg::ctrl_t'(wdata[6:0]);
                        end
                    end else if (rd_fire) begin
                        state <= colmix_pkg::RD_WAIT;
                    end
                end
                colmix_pkg::WR_RESP: if (bready) state <= colmix_pkg::IDLE;
                // Palette port needs one clock for its registered read
                colmix_pkg::RD_WAIT: state <= colmix_pkg::RD_RESP;
                colmix_pkg::RD_RESP: if (rready) state <= colmix_pkg::IDLE;
                default: state <= colmix_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_ok ? colmix_pkg::RESP_OKAY : colmix_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            rd_addr_q <= araddr;
        end
    end

    assign bvalid      = (state == colmix_pkg::WR_RESP);
    assign rvalid      = (state == colmix_pkg::RD_RESP);
    assign pal_rd_addr = rd_addr_q[11:2];
    assign rd_reg      = decode(rd_addr_q);

    // Priority table is write-only and reads back as zero
    always_comb begin
        case (rd_reg)
            REG_PAL:  rdata = {8'h00, pal_rd_data};
            REG_CTRL: rdata = {25'd0, ctrl};
            default:  rdata = '0;
        endcase
        rresp = (rd_reg == REG_NONE) ? colmix_pkg::RESP_SLVERR : colmix_pkg::RESP_OKAY;
    end

    a_one_resp: assert property (
        @(posedge clk) disable iff (reset)
        !(bvalid && rvalid)
    );

    // Palette data must hold while the master stalls R
    a_rdata_hold: assert property (
        @(posedge clk) disable iff (reset)
        (rvalid && !rready) |=> $stable(rdata)
    );

endmodule

/* rtl/colmix_pkg.sv */
// Shared widths, bus structs, state encodings and AXI register map for the colour mixer
package colmix_pkg;

    localparam int PAL_DEPTH  = 1024;
    localparam int PRIO_DEPTH = 1024;

    typedef logic [7:0]  layer_pix_t;
    typedef logic [9:0]  pal_addr_t;
    typedef logic [9:0]  prio_addr_t;
    typedef logic [15:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;

    // Priority table entry, the layer that wins the pixel
    typedef enum logic [1:0] {BA0, OBJ, BA1, BA2} layer_sel_e;

    typedef enum logic [1:0] {IDLE, WR_RESP, RD_WAIT, RD_RESP} axil_state_e;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    typedef struct packed {
        layer_pix_t ba0;
        layer_pix_t obj;
        layer_pix_t ba1;
        layer_pix_t ba2;
    } layers_t;

    // Same bit layout as the CTRL register, layer_en[0] is BA0
    typedef struct packed {
        logic [3:0] layer_en;
        logic [2:0] prisel;
    } ctrl_t;

    // be[0] blue, be[1] green, be[2] red
    typedef struct packed {
        logic       we;
        pal_addr_t  addr;
        color_t     data;
        logic [2:0] be;
    } pal_wr_t;

    typedef struct packed {
        logic       we;
        prio_addr_t addr;
        layer_sel_e sel;
    } prio_wr_t;

    typedef struct packed {
        logic pxl_cen;
        logic hblank_n;
        logic vblank_n;
    } vid_t;

    localparam ctrl_t CTRL_RESET = '{layer_en: 4'hf, prisel: 3'd0};

    localparam axi_addr_t PAL_BASE  = 16'h0000;
    localparam axi_addr_t PRIO_BASE = 16'h1000;
    localparam axi_addr_t CTRL_ADDR = 16'h2000;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* rtl/colmix_top.sv */
// Colour mixer top level, ties timer, CPU slave, layer priority, palette and blanking together
`timescale 1ns/1ps

module colmix_top #(
    parameter int  PXL_DIV  = 2,
    parameter int  H_TOTAL  = 20,
    parameter int  H_ACTIVE = 16,
    parameter int  V_TOTAL  = 10,
    parameter int  V_ACTIVE = 8,
    localparam int HW       = $clog2(H_TOTAL),
    localparam int VW       = $clog2(V_TOTAL)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  colmix_pkg::axi_addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  colmix_pkg::axi_data_t wdata,
    input  colmix_pkg::axi_strb_t wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  colmix_pkg::axi_addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output colmix_pkg::axi_data_t rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    input  colmix_pkg::layers_t   layers,
    output colmix_pkg::vid_t      vid,
    output logic [HW-1:0]         h_count,
    output logic [VW-1:0]         v_count,
    output colmix_pkg::color_t    color,
    output logic                  hblank_n_dly,
    output logic                  vblank_n_dly
);

    colmix_pkg::pal_wr_t   pal_wr;
    colmix_pkg::pal_addr_t pal_rd_addr;
    colmix_pkg::color_t    pal_rd_data;
    colmix_pkg::prio_wr_t  prio_wr;
    colmix_pkg::ctrl_t     ctrl;
    colmix_pkg::pal_addr_t vid_pal_addr;
    colmix_pkg::color_t    vid_color;

    video_timer #(
        .PXL_DIV  (PXL_DIV),
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) u_timer (
        .clk     (clk),
        .reset   (reset),
        .vid     (vid),
        .h_count (h_count),
        .v_count (v_count)
    );

    colmix_axil_fsm u_axil (
        .clk         (clk),
        .reset       (reset),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .pal_wr      (pal_wr),
        .pal_rd_addr (pal_rd_addr),
        .pal_rd_data (pal_rd_data),
        .prio_wr     (prio_wr),
        .ctrl        (ctrl)
    );

    layer_priority u_prio (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (vid.pxl_cen),
        .layers   (layers),
        .ctrl     (ctrl),
        .prio_wr  (prio_wr),
        .pal_addr (vid_pal_addr)
    );

    palette_ram u_pal (
        .clk       (clk),
        .pal_wr    (pal_wr),
        .cpu_addr  (pal_rd_addr),
        .cpu_data  (pal_rd_data),
        .vid_addr  (vid_pal_addr),
        .vid_color (vid_color)
    );

    blank_delay u_blank (
        .clk          (clk),
        .reset        (reset),
        .vid          (vid),
        .color_in     (vid_color),
        .color        (color),
        .hblank_n_dly (hblank_n_dly),
        .vblank_n_dly (vblank_n_dly)
    );

endmodule

/* rtl/layer_priority.sv */
// Layer selection stage: priority table lookup from transparency flags, yields the palette index
`timescale 1ns/1ps

module layer_priority (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  colmix_pkg::layers_t   layers,
    input  colmix_pkg::ctrl_t     ctrl,
    input  colmix_pkg::prio_wr_t  prio_wr,
    output colmix_pkg::pal_addr_t pal_addr
);

    colmix_pkg::layer_sel_e prio_mem [colmix_pkg::PRIO_DEPTH];
    colmix_pkg::prio_addr_t prio_idx;
    colmix_pkg::prio_addr_t prio_addr_q;
    colmix_pkg::layers_t    pix_q;
    colmix_pkg::layer_sel_e sel;
    colmix_pkg::layer_pix_t sel_pix;
    logic                   ba0_clear;
    logic                   obj_clear;
    logic                   ba1_clear;
    logic                   ba2_clear;

    // Transparent on a zero colour code or a disabled layer
    assign ba0_clear = ~|layers.ba0[3:0] | ~ctrl.layer_en[0];
    assign obj_clear = ~|layers.obj[3:0] | ~ctrl.layer_en[1];
    // BA1 only looks at three bits here
    assign ba1_clear = ~|layers.ba1[2:0] | ~ctrl.layer_en[2];
    assign ba2_clear = ~|layers.ba2[3:0] | ~ctrl.layer_en[3];

    assign prio_idx = {ctrl.prisel, ba0_clear, layers.obj[7], obj_clear,
                       layers.ba1[7], layers.ba1[3], ba1_clear, ba2_clear};

    always_ff @(posedge clk) begin
        if (prio_wr.we) begin
            prio_mem[prio_wr.addr] <= prio_wr.sel;
        end
    end

    // Pixels travel with the table index
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pix_q <= layers;
        end
    end

    assign sel = prio_mem[prio_addr_q];

    always_comb begin
        case (sel)
            colmix_pkg::BA0: sel_pix = pix_q.ba0;
            colmix_pkg::OBJ: sel_pix = pix_q.obj;
            colmix_pkg::BA1: sel_pix = pix_q.ba1;
            default:         sel_pix = pix_q.ba2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_addr_q <= '0;
            pal_addr    <= '0;
        end else if (pxl_cen) begin
            prio_addr_q <= prio_idx;
            // Layer number lands in the top two bits
            pal_addr    <= {sel, sel_pix};
        end
    end

endmodule

/* rtl/palette_ram.sv */
// Palette memory, CPU port with per-colour byte writes plus a registered video read port
`timescale 1ns/1ps

module palette_ram (
    input  logic                  clk,
    input  colmix_pkg::pal_wr_t   pal_wr,
    input  colmix_pkg::pal_addr_t cpu_addr,
    output colmix_pkg::color_t    cpu_data,
    input  colmix_pkg::pal_addr_t vid_addr,
    output colmix_pkg::color_t    vid_color
);

    colmix_pkg::color_t mem [colmix_pkg::PAL_DEPTH];

    // CPU side, each colour byte has its own enable
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            if (pal_wr.be[0]) begin
                mem[pal_wr.addr].blue <= pal_wr.data.blue;
            end
            if (pal_wr.be[1]) begin
                mem[pal_wr.addr].green <= pal_wr.data.green;
            end
            if (pal_wr.be[2]) begin
                mem[pal_wr.addr].red <= pal_wr.data.red;
            end
        end
        cpu_data <= mem[cpu_addr];
    end

    // Video side reads every clock
    always_ff @(posedge clk) begin
        vid_color <= mem[vid_addr];
    end

endmodule

/* rtl/video_timer.sv */
// Raster timer: pixel clock enable, line/frame counters and active-low blanking for the layers
`timescale 1ns/1ps

module video_timer #(
    parameter int  PXL_DIV  = 2,
    parameter int  H_TOTAL  = 20,
    parameter int  H_ACTIVE = 16,
    parameter int  V_TOTAL  = 10,
    parameter int  V_ACTIVE = 8,
    localparam int HW       = $clog2(H_TOTAL),
    localparam int VW       = $clog2(V_TOTAL)
) (
    input  logic             clk,
    input  logic             reset,
    output colmix_pkg::vid_t vid,
    output logic [HW-1:0]    h_count,
    output logic [VW-1:0]    v_count
);

    localparam int DIV_W = (PXL_DIV > 1) ? $clog2(PXL_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             cen;

    // One enable per PXL_DIV clocks, on the last count
    assign cen = (div_cnt == DIV_W'(PXL_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            h_count <= '0;
            v_count <= '0;
        end else begin
            div_cnt <= cen ? '0 : div_cnt + 1'b1;
            if (cen) begin
                if (h_count == HW'(H_TOTAL - 1)) begin
                    h_count <= '0;
                    // Line wrap steps the frame counter
                    v_count <= (v_count == VW'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
                end else begin
                    h_count <= h_count + 1'b1;
                end
            end
        end
    end

    assign vid.pxl_cen  = cen;
    assign vid.hblank_n = (h_count < HW'(H_ACTIVE));
    assign vid.vblank_n = (v_count < VW'(V_ACTIVE));

    // Enable must be a single-cycle pulse when dividing
    a_cen_pulse: assert property (
        @(posedge clk) disable iff (reset)
        (PXL_DIV > 1 && vid.pxl_cen) |=> !vid.pxl_cen
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the colour mixer testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module colmix_tb -o colmix_sim \
    > build.log 2>&1 \
    && ./obj_dir/colmix_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error, see build.log and sim.log"
grep -q "^all tests passed$" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

/* verif/colmix_stim.txt */
// Columns: op addr data strb resp stall, hex. op 1 write, 2 read (data and resp expected),
// 3 pixel test (addr is ctrl, data is pixel count), 4 fill region (data is word count), 0 end
4 0000 00000400 0 0 0
4 1000 00000400 0 0 0
1 0010 00a1b2c3 f 0 0
1 0010 00ffeedd 2 0 0
2 0010 00a1eec3 0 0 0
1 0014 00112233 5 0 3
2 0014 00110533 0 0 0
2 0ffc 00ffffa5 0 0 2
1 2000 0000ffad 1 0 0
2 2000 0000002d 0 0 0
1 2000 00000000 2 2 0
2 2000 0000002d 0 0 0
2 1004 00000000 0 0 0
1 3000 12345678 f 2 4
2 2004 00000000 0 2 5
1 1000 00000001 1 0 0
1 103c 00000003 1 0 0
1 10a8 00000002 1 0 0
1 1a00 00000002 1 0 0
1 1bfc 00000000 1 0 0
3 0078 000000c8 0 0 0
3 002d 000000c8 0 0 0
3 0003 000000c8 0 0 0
2 2000 00000003 0 0 0
0 0000 00000000 0 0 0

/* verif/colmix_tb.sv */
// Testbench for the colour mixer, runs the bus and pixel records of the stim file against a model
`timescale 1ns/1ps

module colmix_tb;

    localparam int PXL_DIV    = 2;
    localparam int H_TOTAL    = 20;
    localparam int H_ACTIVE   = 16;
    localparam int V_TOTAL    = 10;
    localparam int V_ACTIVE   = 8;
    localparam int FRAME_CLKS = PXL_DIV * H_TOTAL * V_TOTAL;
    localparam int REC_MAX    = 32;

    // One expected pixel, colour plus the blanking it was sampled with
    typedef struct packed {
        colmix_pkg::color_t color;
        logic               hb;
        logic               vb;
    } pix_exp_t;

    logic                  clk;
    logic                  reset;
    colmix_pkg::axi_addr_t awaddr;
    logic                  awvalid;
    logic                  awready;
    colmix_pkg::axi_data_t wdata;
    colmix_pkg::axi_strb_t wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    colmix_pkg::axi_addr_t araddr;
    logic                  arvalid;
    logic                  arready;
    colmix_pkg::axi_data_t rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    colmix_pkg::layers_t   layers;
    colmix_pkg::vid_t      vid;
    logic [4:0]            h_count;
    logic [3:0]            v_count;
    colmix_pkg::color_t    color;
    logic                  hblank_n_dly;
    logic                  vblank_n_dly;

    colmix_pkg::color_t     pal_shadow [colmix_pkg::PAL_DEPTH];
    colmix_pkg::layer_sel_e prio_shadow [colmix_pkg::PRIO_DEPTH];
    colmix_pkg::ctrl_t      ctrl_shadow;
    logic [31:0]            stim [REC_MAX*6];
    pix_exp_t               exp_q [$];
    logic [31:0]            lfsr;
    int                     err_count;
    int                     check_count;
    int                     budget;
    // Clocks since reset release
    int                     clk_n;

    colmix_top #(
        .PXL_DIV  (PXL_DIV),
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            clk_n <= 0;
        end else begin
            clk_n <= clk_n + 1;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_color(input string name, input colmix_pkg::color_t got,
                               input colmix_pkg::color_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_data(input string name, input colmix_pkg::axi_data_t got,
                              input colmix_pkg::axi_data_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pos(input string name, input int got, input int exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // Raster position from the clock count, checked against the timer outputs
    task automatic check_raster(output logic cen, output logic hb, output logic vb);
        int pix;
        int h;
        int v;
        pix = clk_n / PXL_DIV;
        h   = pix % H_TOTAL;
        v   = (pix / H_TOTAL) % V_TOTAL;
        cen = ((clk_n % PXL_DIV) == PXL_DIV - 1);
        hb  = (h < H_ACTIVE);
        vb  = (v < V_ACTIVE);
        check_flag("pxl_cen", vid.pxl_cen, cen);
        check_flag("hblank_n", vid.hblank_n, hb);
        check_flag("vblank_n", vid.vblank_n, vb);
        check_pos("h_count", int'(h_count), h);
        check_pos("v_count", int'(v_count), v);
    endtask

    // Fill patterns, every address bit reaches the value
    function automatic colmix_pkg::axi_data_t pal_fill(input logic [9:0] i);
        return {8'h00, i[9:2], i[7:0], {i[1:0], i[9:4]} ^ 8'h5a};
    endfunction

    function automatic colmix_pkg::axi_data_t prio_fill(input logic [9:0] i);
        return {30'd0, i[9:8] ^ i[7:6] ^ i[5:4] ^ i[3:2] ^ i[1:0]};
    endfunction

    task automatic shadow_write(input colmix_pkg::axi_addr_t a, input colmix_pkg::axi_data_t d,
                                input colmix_pkg::axi_strb_t s);
        logic [9:0] idx;
        idx = a[11:2];
        if (a[15:12] == colmix_pkg::PAL_BASE[15:12]) begin
            if (s[0]) pal_shadow[idx].blue = d[7:0];
            if (s[1]) pal_shadow[idx].green = d[15:8];
            if (s[2]) pal_shadow[idx].red = d[23:16];
        end else if (a[15:12] == colmix_pkg::PRIO_BASE[15:12]) begin
            if (s[0]) prio_shadow[idx] = colmix_pkg::layer_sel_e'(d[1:0]);
        end else if (a[15:2] == colmix_pkg::CTRL_ADDR[15:2] && s[0]) begin
            ctrl_shadow = colmix_pkg::ctrl_t'(d[6:0]);
        end
    endtask

    // Reference colour for one pixel from the transparency and table rules
    function automatic colmix_pkg::color_t expect_color(input colmix_pkg::layers_t l,
                                                        input colmix_pkg::ctrl_t c);
        logic                   ba0_t;
        logic                   obj_t;
        logic                   ba1_t;
        logic                   ba2_t;
        colmix_pkg::prio_addr_t idx;
        colmix_pkg::layer_sel_e sel;
        colmix_pkg::layer_pix_t pix;
        ba0_t = (l.ba0[3:0] == 4'h0) || !c.layer_en[0];
        obj_t = (l.obj[3:0] == 4'h0) || !c.layer_en[1];
        ba1_t = (l.ba1[2:0] == 3'h0) || !c.layer_en[2];
        ba2_t = (l.ba2[3:0] == 4'h0) || !c.layer_en[3];
        idx   = {c.prisel, ba0_t, l.obj[7], obj_t, l.ba1[7], l.ba1[3], ba1_t, ba2_t};
        sel   = prio_shadow[idx];
        case (sel)
            colmix_pkg::BA0: pix = l.ba0;
            colmix_pkg::OBJ: pix = l.obj;
            colmix_pkg::BA1: pix = l.ba1;
            default:         pix = l.ba2;
        endcase
        return pal_shadow[{sel, pix}];
    endfunction

    task automatic bus_write(input colmix_pkg::axi_addr_t a, input colmix_pkg::axi_data_t d,
                             input colmix_pkg::axi_strb_t s, input logic [1:0] exp_resp,
                             input int stall);
        logic [1:0] resp;
        int         wait_n;
        @(negedge clk);
        awaddr  = a;
        wdata   = d;
        wstrb   = s;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_n  = 0;
        while (!bvalid && wait_n < 20) begin
            @(negedge clk);
            wait_n++;
        end
        shadow_write(a, d, s);
        if (!bvalid) begin
            err_count++;
            $display("Write to address 0x%h never got a B response", a);
        end else begin
            resp = bresp;
            check_resp("bresp", resp, exp_resp);
            // Response must hold while the master stalls B
            repeat (stall) begin
                @(negedge clk);
                check_flag("bvalid", bvalid, 1'b1);
                check_resp("bresp", bresp, resp);
            end
            bready = 1'b1;
            @(negedge clk);
            bready = 1'b0;
        end
    endtask

    task automatic bus_read(input colmix_pkg::axi_addr_t a, input colmix_pkg::axi_data_t exp_data,
                            input logic [1:0] exp_resp, input int stall);
        colmix_pkg::axi_data_t data;
        logic [1:0]            resp;
        int                    wait_n;
        @(negedge clk);
        araddr  = a;
        arvalid = 1'b1;
        @(negedge clk);
        arvalid = 1'b0;
        wait_n  = 0;
        while (!rvalid && wait_n < 20) begin
            @(negedge clk);
            wait_n++;
        end
        if (!rvalid) begin
            err_count++;
            $display("Read from address 0x%h never got an R response", a);
        end else begin
            data = rdata;
            resp = rresp;
            check_data("rdata", data, exp_data);
            check_resp("rresp", resp, exp_resp);
            repeat (stall) begin
                @(negedge clk);
                check_flag("rvalid", rvalid, 1'b1);
                check_data("rdata", rdata, data);
                check_resp("rresp", rresp, resp);
            end
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
        end
    endtask

    task automatic fill_region(input colmix_pkg::axi_addr_t base, input int words);
        int                    i;
        colmix_pkg::axi_data_t d;
        for (i = 0; i < words; i++) begin
            if (base[15:12] == colmix_pkg::PRIO_BASE[15:12]) begin
                d = prio_fill(10'(i));
            end else begin
                d = pal_fill(10'(i));
            end
            bus_write(base + 16'(i * 4), d, 4'hf, colmix_pkg::RESP_OKAY, 0);
        end
    endtask

    task automatic pixel_test(input colmix_pkg::ctrl_t c, input int n);
        logic [31:0]         bits;
        colmix_pkg::layers_t l;
        pix_exp_t            e;
        logic                cen_seen;
        logic                cen;
        logic                hb;
        logic                vb;
        int                  checked;
        bus_write(colmix_pkg::CTRL_ADDR, {25'd0, c}, 4'h1, colmix_pkg::RESP_OKAY, 0);
        exp_q.delete();
        cen_seen = 1'b0;
        checked  = 0;
        while (checked < n) begin
            @(negedge clk);
            check_raster(cen, hb, vb);
            // Output after the third enable, counting the sampling one
            if (cen_seen && exp_q.size() == 3) begin
                e = exp_q.pop_front();
                check_flag("hblank_n_dly", hblank_n_dly, e.hb);
                check_flag("vblank_n_dly", vblank_n_dly, e.vb);
                check_color("color", color, e.color);
                checked++;
            end
            cen_seen = cen;
            if (cen) begin
                take_bits(32, bits);
                l       = colmix_pkg::layers_t'(bits);
                layers  = l;
                e.hb    = hb;
                e.vb    = vb;
                e.color = (e.hb && e.vb) ? expect_color(l, ctrl_shadow) : '0;
                exp_q.push_back(e);
            end
        end
    endtask

    function automatic int record_cycles(input logic [31:0] op, input logic [31:0] count);
        case (op)
            32'd3:   return 4 * FRAME_CLKS + 50;
            32'd4:   return 50 * int'(count);
            default: return 50;
        endcase
    endfunction

    task automatic run_record(input int r);
        colmix_pkg::axi_addr_t a;
        colmix_pkg::axi_data_t d;
        a = stim[r*6+1][15:0];
        d = stim[r*6+2];
        case (stim[r*6])
            32'd1:   bus_write(a, d, stim[r*6+3][3:0], stim[r*6+4][1:0], int'(stim[r*6+5]));
            32'd2:   bus_read(a, d, stim[r*6+4][1:0], int'(stim[r*6+5]));
            32'd3:   pixel_test(colmix_pkg::ctrl_t'(a[6:0]), int'(d));
            32'd4:   fill_region(a, int'(d));
            default: begin
                err_count++;
                $display("Stim record %0d has an unknown operation code", r);
            end
        endcase
    endtask

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", budget);
        $display("tests failed");
        $finish;
    end

    initial begin
        int r;
        int total;
        reset       = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        layers      = '0;
        lfsr        = 32'h85571239;
        err_count   = 0;
        check_count = 0;
        ctrl_shadow = colmix_pkg::CTRL_RESET;
        for (r = 0; r < REC_MAX * 6; r++) begin
            stim[r] = '0;
        end
        $readmemh("verif/colmix_stim.txt", stim);
        total = 100;
        for (r = 0; r < REC_MAX && stim[r*6] != 32'd0; r++) begin
            total += record_cycles(stim[r*6], stim[r*6+2]);
        end
        budget = total;

        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag("awready", awready, 1'b0);
        check_flag("wready", wready, 1'b0);
        check_flag("arready", arready, 1'b0);
        check_flag("bvalid", bvalid, 1'b0);
        check_flag("rvalid", rvalid, 1'b0);
        check_flag("hblank_n_dly", hblank_n_dly, 1'b0);
        check_flag("vblank_n_dly", vblank_n_dly, 1'b0);
        check_color("color", color, '0);

        for (r = 0; r < REC_MAX && stim[r*6] != 32'd0; r++) begin
            run_record(r);
        end

        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
